//--- pma_pkg.sv
/*
 * Shared definitions for the PMA checker
 * Width typedefs, region attribute bit positions and the APB register map
 */
package pma_pkg;

  // Byte address as seen on the core memory port
  typedef logic [31:0] addr_t;

  // Region bounds are stored as word addresses
  typedef logic [29:0] word_addr_t;

  // Enough to name any of the PMA_MAX_REGIONS entries
  typedef logic [3:0] region_idx_t;

  // Upper limit for the NUM_REGIONS parameter
  localparam int PMA_MAX_REGIONS = 16;

  // Attribute word layout, one bit per attribute
  localparam int ATTR_W = 4;

  typedef logic [ATTR_W-1:0] attr_t;

  localparam int ATTR_MAIN       = 0;
  localparam int ATTR_BUFFERABLE = 1;
  localparam int ATTR_CACHEABLE  = 2;
  localparam int ATTR_INTEGRITY  = 3;

  // APB register map
  // Each region owns a group of four word registers, the last one reserved
  localparam int REG_STRIDE = 16;

  localparam int REG_LOW  = 0;
  localparam int REG_HIGH = 4;
  localparam int REG_ATTR = 8;

endpackage

//--- pma_apb_regs.sv
/*
 * APB slave for the PMA region table
 * Low bound, high bound and attribute registers per region,
 * registered read-back and error response for bad addresses
 */
`timescale 1ns/1ps
`default_nettype none

module pma_apb_regs import pma_pkg::*; #(
  parameter int NUM_REGIONS = 4
) (
  input  wire  logic                              clk,
  input  wire  logic                              reset_i,

  input  wire  logic                              psel_i,
  input  wire  logic                              penable_i,
  input  wire  logic                              pwrite_i,
  input  wire  addr_t                             paddr_i,
  input  wire  logic [31:0]                       pwdata_i,
  output logic [31:0]                             prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,

  output word_addr_t [PMA_MAX_REGIONS-1:0]        region_low_o,
  output word_addr_t [PMA_MAX_REGIONS-1:0]        region_high_o,
  output attr_t      [PMA_MAX_REGIONS-1:0]        region_attr_o
);

  localparam int OFS_W = $clog2(REG_STRIDE);

  logic [$bits(addr_t)-OFS_W-1:0] grp;
  logic [OFS_W-1:0]               ofs;
  region_idx_t                    idx;
  logic                           sel_low;
  logic                           sel_high;
  logic                           sel_attr;
  logic                           addr_err;
  logic                           setup_phase;
  logic                           access_done;
  logic [31:0]                    rdata;

  // The group number picks the region and the word offset picks the register
  // Byte bits below the word are ignored, so unaligned addresses hit their word
  assign grp = paddr_i[$bits(addr_t)-1:OFS_W];
  assign ofs = {paddr_i[OFS_W-1:2], 2'b00};
  assign idx = grp[$bits(region_idx_t)-1:0];

  assign sel_low  = (ofs == OFS_W'(REG_LOW));
  assign sel_high = (ofs == OFS_W'(REG_HIGH));
  assign sel_attr = (ofs == OFS_W'(REG_ATTR));

  // Regions past NUM_REGIONS and the reserved fourth word both answer with an error
  assign addr_err = (grp >= NUM_REGIONS) || !(sel_low || sel_high || sel_attr);

  assign setup_phase = psel_i && !penable_i;
  assign access_done = psel_i && penable_i && pready_o;

  always_comb begin
    rdata = '0;
    if (!addr_err) begin
      if (sel_low) begin
        rdata = 32'(region_low_o[idx]);
      end else if (sel_high) begin
        rdata = 32'(region_high_o[idx]);
      end else begin
        rdata = 32'(region_attr_o[idx]);
      end
    end
  end

  // Zero wait states: the response is prepared during the setup phase,
  // so pready_o is high throughout the following access phase
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= setup_phase;
      pslverr_o <= setup_phase && addr_err;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_phase) begin
      prdata_o <= pwrite_i ? '0 : rdata;
    end
  end

  // Entries at or above NUM_REGIONS are never written and stay zero
  always_ff @(posedge clk) begin
    if (reset_i) begin
      region_low_o  <= '0;
      region_high_o <= '0;
      region_attr_o <= '0;
    end else if (access_done && pwrite_i && !pslverr_o) begin
      if (sel_low) begin
        region_low_o[idx] <= pwdata_i[$bits(word_addr_t)-1:0];
      end
      if (sel_high) begin
        region_high_o[idx] <= pwdata_i[$bits(word_addr_t)-1:0];
      end
      if (sel_attr) begin
        region_attr_o[idx] <= pwdata_i[ATTR_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- pma_region_match.sv
/*
 * First PMA pipeline stage
 * Parallel region compare, lowest-index priority pick and debug window check
 */
`timescale 1ns/1ps
`default_nettype none

module pma_region_match import pma_pkg::*; #(
  parameter int    NUM_REGIONS     = 4,
  parameter addr_t DM_REGION_START = 32'h1A110800,
  parameter addr_t DM_REGION_END   = 32'h1A110FFF
) (
  input  wire  logic                          clk,
  input  wire  logic                          reset_i,

  input  wire  logic                          req_valid_i,
  input  wire  addr_t                         req_addr_i,
  input  wire  logic                          req_dbg_i,
  input  wire  logic                          req_load_i,
  input  wire  logic                          req_misaligned_i,
  input  wire  logic                          req_pushpop_i,

  input  wire  word_addr_t [PMA_MAX_REGIONS-1:0] region_low_i,
  input  wire  word_addr_t [PMA_MAX_REGIONS-1:0] region_high_i,
  input  wire  attr_t      [PMA_MAX_REGIONS-1:0] region_attr_i,

  output logic                                s1_valid_o,
  output logic                                s1_have_match_o,
  output region_idx_t                         s1_match_idx_o,
  output attr_t                               s1_attr_o,
  output logic                                s1_dmregion_o,
  output logic                                s1_dbg_o,
  output logic                                s1_load_o,
  output logic                                s1_misaligned_o,
  output logic                                s1_pushpop_o
);

  logic [33:0]                addr_ext;
  logic [PMA_MAX_REGIONS-1:0] match_list;
  logic                       have_match;
  region_idx_t                match_idx;
  attr_t                      match_attr;
  logic                       dmregion;

  // Bounds are word addresses, compared against the byte address in 34 bits
  assign addr_ext = {2'b00, req_addr_i};

  always_comb begin
    for (int i = 0; i < PMA_MAX_REGIONS; i++) begin
      match_list[i] = (i < NUM_REGIONS) &&
                      ({2'b00, region_low_i[i], 2'b00} <= addr_ext) &&
                      (addr_ext < {2'b00, region_high_i[i], 2'b00});
    end
  end

  // Scan from the top down so that the lowest matching index is the one left standing
  always_comb begin
    have_match = 1'b0;
    match_idx  = '0;
    match_attr = '0;
    for (int i = PMA_MAX_REGIONS - 1; i >= 0; i--) begin
      if (match_list[i]) begin
        have_match = 1'b1;
        match_idx  = region_idx_t'(i);
        match_attr = region_attr_i[i];
      end
    end
  end

  // Debug module window, both ends inclusive
  assign dmregion = (DM_REGION_START <= req_addr_i) && (req_addr_i <= DM_REGION_END);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1_valid_o <= 1'b0;
    end else begin
      s1_valid_o <= req_valid_i;
    end
  end

  // Payload only moves with a valid request and holds otherwise
  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      s1_have_match_o <= have_match;
      s1_match_idx_o  <= match_idx;
      s1_attr_o       <= match_attr;
      s1_dmregion_o   <= dmregion;
      s1_dbg_o        <= req_dbg_i;
      s1_load_o       <= req_load_i;
      s1_misaligned_o <= req_misaligned_i;
      s1_pushpop_o    <= req_pushpop_i;
    end
  end

endmodule

`default_nettype wire

//--- pma_attr_resolve.sv
/*
 * Second PMA pipeline stage
 * Default and debug configurations, bufferable masking, allow decision
 * and the registered response
 */
`timescale 1ns/1ps
`default_nettype none

module pma_attr_resolve import pma_pkg::*; #(
  parameter int NUM_REGIONS   = 4,
  parameter bit IS_INSTR_SIDE = 1'b0
) (
  input  wire  logic        clk,
  input  wire  logic        reset_i,

  input  wire  logic        s1_valid_i,
  input  wire  logic        s1_have_match_i,
  input  wire  region_idx_t s1_match_idx_i,
  input  wire  attr_t       s1_attr_i,
  input  wire  logic        s1_dmregion_i,
  input  wire  logic        s1_dbg_i,
  input  wire  logic        s1_load_i,
  input  wire  logic        s1_misaligned_i,
  input  wire  logic        s1_pushpop_i,

  output logic              rsp_valid_o,
  output logic              rsp_allow_o,
  output logic              rsp_main_o,
  output logic              rsp_bufferable_o,
  output logic              rsp_cacheable_o,
  output logic              rsp_integrity_o,
  output logic              rsp_override_dm_o,
  output logic              rsp_dmregion_o,
  output logic              rsp_have_match_o,
  output region_idx_t       rsp_match_idx_o
);

  // Without any regions all memory counts as main memory
  localparam attr_t CFG_DEFAULT = (NUM_REGIONS == 0) ? attr_t'(1 << ATTR_MAIN) : '0;
  localparam attr_t CFG_DEBUG   = attr_t'(1 << ATTR_MAIN);

  logic  override_dm;
  attr_t cfg;
  logic  allow_data;
  logic  allow;

  assign override_dm = s1_dbg_i && s1_dmregion_i;

  always_comb begin
    if (override_dm) begin
      cfg = CFG_DEBUG;
    end else if (s1_have_match_i) begin
      cfg = s1_attr_i;
    end else begin
      cfg = CFG_DEFAULT;
    end
    // Fetches and loads never see a bufferable region
    if (IS_INSTR_SIDE || s1_load_i) begin
      cfg[ATTR_BUFFERABLE] = 1'b0;
    end
  end

  assign allow_data = cfg[ATTR_MAIN] || (!s1_misaligned_i && !s1_pushpop_i);
  assign allow      = override_dm || (IS_INSTR_SIDE ? cfg[ATTR_MAIN] : allow_data);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= s1_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid_i) begin
      rsp_allow_o       <= allow;
      rsp_main_o        <= cfg[ATTR_MAIN];
      rsp_bufferable_o  <= cfg[ATTR_BUFFERABLE];
      rsp_cacheable_o   <= cfg[ATTR_CACHEABLE];
      rsp_integrity_o   <= cfg[ATTR_INTEGRITY];
      rsp_override_dm_o <= override_dm;
      rsp_dmregion_o    <= s1_dmregion_i;
      rsp_have_match_o  <= s1_have_match_i;
      rsp_match_idx_o   <= s1_match_idx_i;
    end
  end

endmodule

`default_nettype wire

//--- pma_top.sv
/*
 * PMA checker top level
 * APB region table, match stage and resolve stage
 */
`timescale 1ns/1ps
`default_nettype none

module pma_top import pma_pkg::*; #(
  parameter int    NUM_REGIONS     = 4,
  parameter bit    IS_INSTR_SIDE   = 1'b0,
  parameter addr_t DM_REGION_START = 32'h1A110800,
  parameter addr_t DM_REGION_END   = 32'h1A110FFF
) (
  input  wire  logic        clk,
  input  wire  logic        reset_i,

  input  wire  logic        psel_i,
  input  wire  logic        penable_i,
  input  wire  logic        pwrite_i,
  input  wire  addr_t       paddr_i,
  input  wire  logic [31:0] pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,

  input  wire  logic        req_valid_i,
  input  wire  addr_t       req_addr_i,
  input  wire  logic        req_dbg_i,
  input  wire  logic        req_load_i,
  input  wire  logic        req_misaligned_i,
  input  wire  logic        req_pushpop_i,

  output logic              rsp_valid_o,
  output logic              rsp_allow_o,
  output logic              rsp_main_o,
  output logic              rsp_bufferable_o,
  output logic              rsp_cacheable_o,
  output logic              rsp_integrity_o,
  output logic              rsp_override_dm_o,
  output logic              rsp_dmregion_o,
  output logic              rsp_have_match_o,
  output region_idx_t       rsp_match_idx_o
);

  word_addr_t [PMA_MAX_REGIONS-1:0] region_low;
  word_addr_t [PMA_MAX_REGIONS-1:0] region_high;
  attr_t      [PMA_MAX_REGIONS-1:0] region_attr;

  logic        s1_valid;
  logic        s1_have_match;
  region_idx_t s1_match_idx;
  attr_t       s1_attr;
  logic        s1_dmregion;
  logic        s1_dbg;
  logic        s1_load;
  logic        s1_misaligned;
  logic        s1_pushpop;

  pma_apb_regs #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_apb_regs (
    .clk           (clk),
    .reset_i       (reset_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .region_low_o  (region_low),
    .region_high_o (region_high),
    .region_attr_o (region_attr)
  );

  pma_region_match #(
    .NUM_REGIONS     (NUM_REGIONS),
    .DM_REGION_START (DM_REGION_START),
    .DM_REGION_END   (DM_REGION_END)
  ) u_region_match (
    .clk              (clk),
    .reset_i          (reset_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_dbg_i        (req_dbg_i),
    .req_load_i       (req_load_i),
    .req_misaligned_i (req_misaligned_i),
    .req_pushpop_i    (req_pushpop_i),
    .region_low_i     (region_low),
    .region_high_i    (region_high),
    .region_attr_i    (region_attr),
    .s1_valid_o       (s1_valid),
    .s1_have_match_o  (s1_have_match),
    .s1_match_idx_o   (s1_match_idx),
    .s1_attr_o        (s1_attr),
    .s1_dmregion_o    (s1_dmregion),
    .s1_dbg_o         (s1_dbg),
    .s1_load_o        (s1_load),
    .s1_misaligned_o  (s1_misaligned),
    .s1_pushpop_o     (s1_pushpop)
  );

  pma_attr_resolve #(
    .NUM_REGIONS   (NUM_REGIONS),
    .IS_INSTR_SIDE (IS_INSTR_SIDE)
  ) u_attr_resolve (
    .clk               (clk),
    .reset_i           (reset_i),
    .s1_valid_i        (s1_valid),
    .s1_have_match_i   (s1_have_match),
    .s1_match_idx_i    (s1_match_idx),
    .s1_attr_i         (s1_attr),
    .s1_dmregion_i     (s1_dmregion),
    .s1_dbg_i          (s1_dbg),
    .s1_load_i         (s1_load),
    .s1_misaligned_i   (s1_misaligned),
    .s1_pushpop_i      (s1_pushpop),
    .rsp_valid_o       (rsp_valid_o),
    .rsp_allow_o       (rsp_allow_o),
    .rsp_main_o        (rsp_main_o),
    .rsp_bufferable_o  (rsp_bufferable_o),
    .rsp_cacheable_o   (rsp_cacheable_o),
    .rsp_integrity_o   (rsp_integrity_o),
    .rsp_override_dm_o (rsp_override_dm_o),
    .rsp_dmregion_o    (rsp_dmregion_o),
    .rsp_have_match_o  (rsp_have_match_o),
    .rsp_match_idx_o   (rsp_match_idx_o)
  );

endmodule

`default_nettype wire

//--- pma_checker.sv
/*
 * Bound assertions for the PMA checker
 * Reset state, two-cycle latency, debug override and APB ready rules
 */
`timescale 1ns/1ps

module pma_checker (
  input logic clk,
  input logic reset_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_o,
  input logic req_valid_i,
  input logic rsp_valid_o,
  input logic rsp_allow_o,
  input logic rsp_override_dm_o
);

  // No response may come out of the pipeline right after reset
  a_reset_clears_valid: assert property (
    @(posedge clk) reset_i |=> !rsp_valid_o
  ) else $error("rsp_valid_o high in the cycle after reset");

  // Every request comes back exactly two cycles later
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (reset_i)
    rsp_valid_o == $past(req_valid_i, 2)
  ) else $error("rsp_valid_o does not follow req_valid_i by two cycles");

  a_override_allows: assert property (
    @(posedge clk) disable iff (reset_i)
    (rsp_valid_o && rsp_override_dm_o) |-> rsp_allow_o
  ) else $error("Debug override response is not allowed");

  // Zero wait states on the APB side
  a_ready_in_access: assert property (
    @(posedge clk) disable iff (reset_i)
    (psel_i && penable_i) |-> pready_o
  ) else $error("pready_o low in an APB access phase");

endmodule

bind pma_top pma_checker u_checker (
  .clk               (clk),
  .reset_i           (reset_i),
  .psel_i            (psel_i),
  .penable_i         (penable_i),
  .pready_o          (pready_o),
  .req_valid_i       (req_valid_i),
  .rsp_valid_o       (rsp_valid_o),
  .rsp_allow_o       (rsp_allow_o),
  .rsp_override_dm_o (rsp_override_dm_o)
);

//--- tb_pma_top.sv
/*
 * Directed testbench for the PMA checker
 * APB and request tasks, reference model, response monitor and watchdog
 */
`timescale 1ns/1ps

module tb_pma_top;

  logic        clk;
  logic        reset_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [31:0] paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic        req_valid_i;
  logic [31:0] req_addr_i;
  logic        req_dbg_i;
  logic        req_load_i;
  logic        req_misaligned_i;
  logic        req_pushpop_i;
  logic        rsp_valid_o;
  logic        rsp_allow_o;
  logic        rsp_main_o;
  logic        rsp_bufferable_o;
  logic        rsp_cacheable_o;
  logic        rsp_integrity_o;
  logic        rsp_override_dm_o;
  logic        rsp_dmregion_o;
  logic        rsp_have_match_o;
  logic [3:0]  rsp_match_idx_o;

  // Shadow copy of the region table as software sees it
  logic [29:0] sh_low [4];
  logic [29:0] sh_high [4];
  logic [3:0]  sh_attr [4];

  // Expected responses are packed as allow main buf cache integ ovr dmr have idx[3:0]
  logic [11:0] exp_q [$];
  time         due_q [$];

  pma_top #(
    .NUM_REGIONS   (4),
    .IS_INSTR_SIDE (1'b0)
  ) u_pma_top (.*);

  always #5 clk = ~clk;

  initial begin
    #20000;
    $display("Timeout: the tests did not finish within 20000 ns");
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Test stopped on error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Some tests failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  function automatic logic apb_err(input logic [31:0] addr);
    return (addr[31:4] >= 28'd4) || (addr[3:2] == 2'd3);
  endfunction

  function automatic logic [31:0] read_model(input logic [31:0] addr);
    if (apb_err(addr)) begin
      return 32'h0;
    end
    case (addr[3:2])
      2'd0: return {2'b00, sh_low[addr[5:4]]};
      2'd1: return {2'b00, sh_high[addr[5:4]]};
      default: return {28'h0, sh_attr[addr[5:4]]};
    endcase
  endfunction

  function automatic logic [11:0] model(input logic [31:0] a, input logic dbg,
                                        input logic load, input logic mis, input logic pp);
    logic       have;
    logic [3:0] idx;
    logic [3:0] cfg;
    logic       dmr;
    logic       ovr;
    logic       allow;
    have = 1'b0;
    idx  = 4'd0;
    cfg  = 4'd0;
    for (int i = 3; i >= 0; i--) begin
      if (({sh_low[i], 2'b00} <= {2'b00, a}) && ({2'b00, a} < {sh_high[i], 2'b00})) begin
        have = 1'b1;
        idx  = 4'(i);
        cfg  = sh_attr[i];
      end
    end
    dmr = (a >= 32'h1A110800) && (a <= 32'h1A110FFF);
    ovr = dbg && dmr;
    // Four regions exist, so the default configuration is all zero
    if (ovr) begin
      cfg = 4'b0001;
    end else if (!have) begin
      cfg = 4'b0000;
    end
    if (load) begin
      cfg[1] = 1'b0;
    end
    allow = ovr || cfg[0] || (!mis && !pp);
    return {allow, cfg[0], cfg[1], cfg[2], cfg[3], ovr, dmr, have, idx};
  endfunction

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk);
    penable_i <= 1'b1;
    @(negedge clk);
    check_val("pready_o", 32'(pready_o), 32'h1);
    check_val("pslverr_o", 32'(pslverr_o), 32'(apb_err(addr)));
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    if (!apb_err(addr)) begin
      case (addr[3:2])
        2'd0: sh_low[addr[5:4]] = data[29:0];
        2'd1: sh_high[addr[5:4]] = data[29:0];
        default: sh_attr[addr[5:4]] = data[3:0];
      endcase
    end
  endtask

  task automatic apb_read(input logic [31:0] addr);
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk);
    penable_i <= 1'b1;
    @(negedge clk);
    check_val("pready_o", 32'(pready_o), 32'h1);
    check_val("pslverr_o", 32'(pslverr_o), 32'(apb_err(addr)));
    check_val("prdata_o", prdata_o, read_model(addr));
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic set_region(input int i, input logic [31:0] lo, input logic [31:0] hi,
                            input logic [3:0] attr);
    apb_write(32'(i * 16), lo >> 2);
    apb_write(32'(i * 16 + 4), hi >> 2);
    apb_write(32'(i * 16 + 8), 32'(attr));
  endtask

  task automatic send_req(input logic [31:0] a, input logic dbg, input logic load,
                          input logic mis, input logic pp);
    @(posedge clk);
    req_valid_i      <= 1'b1;
    req_addr_i       <= a;
    req_dbg_i        <= dbg;
    req_load_i       <= load;
    req_misaligned_i <= mis;
    req_pushpop_i    <= pp;
    exp_q.push_back(model(a, dbg, load, mis, pp));
    // Stage 1 takes it on the next edge and stage 2 one edge later
    due_q.push_back($time + 25);
  endtask

  task automatic req_idle();
    @(posedge clk);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_error("Expected responses never arrived");
    end
  endtask

  // The response monitor samples mid-cycle where outputs are stable
  always @(negedge clk) begin
    logic [11:0] e;
    time         due;
    if (!reset_i && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        report_error("Response arrived without a pending request");
      end
      e   = exp_q.pop_front();
      due = due_q.pop_front();
      if ($time != due) begin
        report_error("Response arrived at the wrong cycle");
      end
      check_val("rsp_allow_o", 32'(rsp_allow_o), 32'(e[11]));
      check_val("rsp_main_o", 32'(rsp_main_o), 32'(e[10]));
      check_val("rsp_bufferable_o", 32'(rsp_bufferable_o), 32'(e[9]));
      check_val("rsp_cacheable_o", 32'(rsp_cacheable_o), 32'(e[8]));
      check_val("rsp_integrity_o", 32'(rsp_integrity_o), 32'(e[7]));
      check_val("rsp_override_dm_o", 32'(rsp_override_dm_o), 32'(e[6]));
      check_val("rsp_dmregion_o", 32'(rsp_dmregion_o), 32'(e[5]));
      check_val("rsp_have_match_o", 32'(rsp_have_match_o), 32'(e[4]));
      check_val("rsp_match_idx_o", 32'(rsp_match_idx_o), 32'(e[3:0]));
    end
  end

  task automatic test_defaults();
    send_req(32'h0000_1000, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_1001, 1'b0, 1'b0, 1'b1, 1'b0);
    send_req(32'h8000_0000, 1'b0, 1'b1, 1'b0, 1'b1);
    send_req(32'hFFFF_FFFC, 1'b0, 1'b1, 1'b0, 1'b0);
    req_idle();
    wait_drain();
  endtask

  task automatic test_registers();
    for (int i = 0; i < 4; i++) begin
      apb_write(32'(i * 16), {2'b11, 30'(32'h0123_4560 + i)});
      apb_write(32'(i * 16 + 4), 32'hA5A5_0000 + 32'(i));
      apb_write(32'(i * 16 + 8), 32'hFFFF_FFF0 + 32'(i * 3));
    end
    for (int i = 0; i < 4; i++) begin
      apb_read(32'(i * 16));
      apb_read(32'(i * 16 + 6));
      apb_read(32'(i * 16 + 8));
    end
    // Bad index and reserved offset
    apb_write(32'h0000_0050, 32'hDEAD_BEEF);
    apb_write(32'h0000_000C, 32'hDEAD_BEEF);
    apb_read(32'h0000_0050);
    apb_read(32'h0000_000C);
    // The rejected writes must not have reached any entry of the table
    for (int i = 0; i < 4; i++) begin
      apb_read(32'(i * 16));
      apb_read(32'(i * 16 + 4));
      apb_read(32'(i * 16 + 8));
    end
  endtask

  task automatic test_priority();
    set_region(0, 32'h0, 32'h0, 4'h0);
    set_region(1, 32'h2000, 32'h3000, 4'h5);
    set_region(2, 32'h2800, 32'h4000, 4'hA);
    set_region(3, 32'h8000, 32'h9000, 4'h2);
    send_req(32'h0000_1FFF, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_2000, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_2800, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_2FFF, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_3000, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_3FFF, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_4000, 1'b0, 1'b0, 1'b0, 1'b0);
    req_idle();
    wait_drain();
  endtask

  task automatic test_debug();
    set_region(0, 32'h1A11_0000, 32'h1A12_0000, 4'h2);
    send_req(32'h1A11_0800, 1'b1, 1'b0, 1'b1, 1'b1);
    send_req(32'h1A11_0FFF, 1'b1, 1'b0, 1'b0, 1'b1);
    send_req(32'h1A11_07FC, 1'b1, 1'b0, 1'b1, 1'b0);
    send_req(32'h1A11_1000, 1'b1, 1'b0, 1'b0, 1'b0);
    send_req(32'h1A11_0800, 1'b0, 1'b0, 1'b1, 1'b1);
    send_req(32'h1A11_0FFF, 1'b0, 1'b1, 1'b0, 1'b0);
    req_idle();
    wait_drain();
  endtask

  task automatic test_bufferable();
    send_req(32'h0000_8100, 1'b0, 1'b0, 1'b0, 1'b0);
    send_req(32'h0000_8100, 1'b0, 1'b1, 1'b0, 1'b0);
    send_req(32'h0000_8101, 1'b0, 1'b0, 1'b1, 1'b0);
    send_req(32'h0000_8104, 1'b0, 1'b0, 1'b0, 1'b1);
    send_req(32'h0000_2101, 1'b0, 1'b0, 1'b1, 1'b0);
    send_req(32'h0000_2104, 1'b0, 1'b1, 1'b0, 1'b1);
    req_idle();
    wait_drain();
  endtask

  task automatic test_stream();
    logic [31:0] bases [6];
    logic [31:0] a;
    int          gap;
    bases = '{32'h0000_2000, 32'h0000_2800, 32'h0000_3800, 32'h0000_8000,
              32'h1A11_0800, 32'h1A11_F000};
    for (int i = 0; i < 200; i++) begin
      if (i == 100) begin
        req_idle();
        wait_drain();
        // Region 3 turns into main memory from here on
        apb_write(32'h0000_0038, 32'h0000_0001);
      end
      if ($urandom % 4 == 0) begin
        a = $urandom;
      end else begin
        a = bases[$urandom % 6] + ($urandom % 32'h900);
      end
      send_req(a, 1'($urandom), 1'($urandom), 1'($urandom), 1'($urandom));
      gap = $urandom % 4;
      if (gap == 3) begin
        req_idle();
        repeat ($urandom % 3) @(posedge clk);
      end
    end
    req_idle();
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'h6cfa));
    clk              = 1'b0;
    reset_i          = 1'b1;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    pwrite_i         = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    req_dbg_i        = 1'b0;
    req_load_i       = 1'b0;
    req_misaligned_i = 1'b0;
    req_pushpop_i    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      sh_low[i]  = '0;
      sh_high[i] = '0;
      sh_attr[i] = '0;
    end
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;

    test_defaults();
    test_registers();
    test_priority();
    test_debug();
    test_bufferable();
    test_stream();

    if (exp_q.size() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
pma_pkg.sv
pma_apb_regs.sv
pma_region_match.sv
pma_attr_resolve.sv
pma_top.sv
pma_checker.sv
tb_pma_top.sv

//--- run.sh
#!/bin/sh
# Build and run the PMA testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_pma_top -f vlog.f -o sim_pma

./obj_dir/sim_pma > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  exit 1
fi
exit 0
